// File: verilog/aluPkg.sv
`default_nettype none

package aluPkg;

	////////////////////////////////////////////////////////////
	// single-precision format
	////////////////////////////////////////////////////////////

	localparam int wordWidth = 32;
	localparam int expWidth = 8;
	localparam int fracWidth = 23;

	localparam logic [wordWidth-1:0] canonicalNan = 32'h7fc00000; // quiet, positive

	typedef enum logic [4:0]
	{
		opAdd = 5'd0,
		opSub = 5'd1,
		opAnd = 5'd2,
		opOr = 5'd3,
		opSltu = 5'd5,
		opFsgnj = 5'd8,
		opFsgnjn = 5'd9,
		opFsgnjx = 5'd10,
		opFmin = 5'd11,
		opFmax = 5'd12,
		opFeq = 5'd13,
		opFlt = 5'd14,
		opFle = 5'd15,
		opFclass = 5'd17,
		opFmv = 5'd18
	} aluOp_t;

	typedef enum logic [1:0]
	{
		stateIdle,
		stateCompute,
		stateHold
	} ctrlState_t;

	////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////

	typedef struct packed
	{
		aluOp_t op;
		logic [wordWidth-1:0] srcA;
		logic [wordWidth-1:0] srcB;
	} aluRequest_t;

	typedef struct packed
	{
		logic [wordWidth-1:0] value;
		logic zero; // operand equality
		logic invalid; // NV
	} aluResult_t;

	typedef struct packed
	{
		logic sign;
		logic isZero;
		logic isSubnormal;
		logic isInf;
		logic isNan;
		logic isSignaling;
	} floatCategory_t;

	typedef struct packed
	{
		logic [wordWidth-1:0] sum;
		logic [wordWidth-1:0] difference;
		logic [wordWidth-1:0] andValue;
		logic [wordWidth-1:0] orValue;
		logic lessUnsigned;
		logic zero;
	} intResult_t;

	typedef struct packed
	{
		logic eq;
		logic lt;
		logic le;
		logic [wordWidth-1:0] minValue;
		logic [wordWidth-1:0] maxValue;
		logic invalidQuiet; // any NaN seen
		logic invalidSignaling; // signaling NaN seen
	} cmpResult_t;

endpackage

`default_nettype wire

// File: verilog/intArith.sv
`timescale 1ns/1ps
`default_nettype none

module intArith
(
	input logic [aluPkg::wordWidth-1:0] opA,
	input logic [aluPkg::wordWidth-1:0] opB,
	output aluPkg::intResult_t intResult
);

	logic [aluPkg::wordWidth-1:0] sum;
	logic [aluPkg::wordWidth-1:0] difference;
	logic [aluPkg::wordWidth:0] borrowDiff;
	logic lessUnsigned;

	// carry out of A - B doubles as the unsigned compare
	assign borrowDiff = {1'b0, opA} - {1'b0, opB};
	assign difference = borrowDiff[aluPkg::wordWidth-1:0];
	assign lessUnsigned = borrowDiff[aluPkg::wordWidth];

	assign sum = opA + opB;

	always_comb
	begin
		intResult.sum = sum;
		intResult.difference = difference;
		intResult.andValue = opA & opB;
		intResult.orValue = opA | opB;
		intResult.lessUnsigned = lessUnsigned;
		intResult.zero = (opA == opB); // bitwise, not float equality
	end

endmodule

`default_nettype wire

// File: verilog/floatClassify.sv
`timescale 1ns/1ps
`default_nettype none

module floatClassify
(
	input logic [aluPkg::wordWidth-1:0] operand,
	output aluPkg::floatCategory_t category,
	output logic [9:0] classMask
);

	localparam int fracTop = aluPkg::fracWidth - 1;

	logic [aluPkg::expWidth-1:0] exponent;
	logic [aluPkg::fracWidth-1:0] fraction;
	logic sign;
	logic expZero;
	logic expOnes;
	logic fracZero;
	logic isNormal;

	assign sign = operand[aluPkg::wordWidth-1];
	assign exponent = operand[aluPkg::wordWidth-2 -: aluPkg::expWidth];
	assign fraction = operand[aluPkg::fracWidth-1:0];

	assign expZero = (exponent == '0);
	assign expOnes = (exponent == '1);
	assign fracZero = (fraction == '0);
	assign isNormal = !expZero && !expOnes;

	always_comb
	begin
		category.sign = sign;
		category.isZero = expZero && fracZero;
		category.isSubnormal = expZero && !fracZero;
		category.isInf = expOnes && fracZero;
		category.isNan = expOnes && !fracZero;
		category.isSignaling = expOnes && !fracZero && !fraction[fracTop]; // quiet bit clear

		classMask[0] = sign && category.isInf;
		classMask[1] = sign && isNormal;
		classMask[2] = sign && category.isSubnormal;
		classMask[3] = sign && category.isZero;
		classMask[4] = !sign && category.isZero;
		classMask[5] = !sign && category.isSubnormal;
		classMask[6] = !sign && isNormal;
		classMask[7] = !sign && category.isInf;
		classMask[8] = category.isSignaling; // NaN sign ignored
		classMask[9] = category.isNan && !category.isSignaling;
	end

endmodule

`default_nettype wire

// File: verilog/floatCompare.sv
`timescale 1ns/1ps
`default_nettype none

module floatCompare
(
	input logic [aluPkg::wordWidth-1:0] opA,
	input logic [aluPkg::wordWidth-1:0] opB,
	input aluPkg::floatCategory_t catA,
	input aluPkg::floatCategory_t catB,
	output aluPkg::cmpResult_t cmpResult
);

	localparam int magWidth = aluPkg::expWidth + aluPkg::fracWidth;

	logic [magWidth-1:0] magA;
	logic [magWidth-1:0] magB;
	logic bothZero;
	logic anyNan;
	logic equal;
	logic aLess;
	logic aBelow;
	logic [aluPkg::wordWidth-1:0] minPick;
	logic [aluPkg::wordWidth-1:0] maxPick;

	assign magA = opA[magWidth-1:0];
	assign magB = opB[magWidth-1:0];
	assign bothZero = catA.isZero && catB.isZero;
	assign anyNan = catA.isNan || catB.isNan;

	////////////////////////////////////////////////////////////
	// ordering of non-NaN values
	////////////////////////////////////////////////////////////

	assign equal = bothZero || (opA == opB); // +0 == -0

	always_comb
	begin
		if (catA.sign != catB.sign)
			aLess = catA.sign && !bothZero;
		else if (catA.sign)
			aLess = magA > magB; // both negative, larger magnitude is smaller
		else
			aLess = magA < magB;
	end

	// min/max treat -0 as below +0
	assign aBelow = aLess || (bothZero && catA.sign && !catB.sign);

	always_comb
	begin
		if (catA.isNan && catB.isNan)
		begin
			minPick = aluPkg::canonicalNan;
			maxPick = aluPkg::canonicalNan;
		end
		else if (catA.isNan)
		begin
			minPick = opB;
			maxPick = opB;
		end
		else if (catB.isNan)
		begin
			minPick = opA;
			maxPick = opA;
		end
		else
		begin
			minPick = aBelow ? opA : opB;
			maxPick = aBelow ? opB : opA;
		end
	end

	always_comb
	begin
		cmpResult.eq = !anyNan && equal;
		cmpResult.lt = !anyNan && aLess;
		cmpResult.le = !anyNan && (aLess || equal);
		cmpResult.minValue = minPick;
		cmpResult.maxValue = maxPick;
		cmpResult.invalidQuiet = anyNan;
		cmpResult.invalidSignaling = catA.isSignaling || catB.isSignaling;
	end

endmodule

`default_nettype wire

// File: verilog/aluControl.sv
`timescale 1ns/1ps
`default_nettype none

module aluControl
(
	input logic clk,
	input logic reset,
	input logic req,
	input aluPkg::aluRequest_t request,
	output logic ack,
	output aluPkg::aluResult_t result,
	output logic [aluPkg::wordWidth-1:0] opA,
	output logic [aluPkg::wordWidth-1:0] opB,
	input aluPkg::intResult_t intResult,
	input aluPkg::cmpResult_t cmpResult,
	input logic [9:0] classMaskA
);

	localparam int signBit = aluPkg::wordWidth - 1;
	localparam int magWidth = aluPkg::expWidth + aluPkg::fracWidth;

	aluPkg::ctrlState_t state;
	aluPkg::aluOp_t opReg;
	aluPkg::aluResult_t nextResult;
	logic [magWidth-1:0] magA;

	assign magA = opA[magWidth-1:0];

	////////////////////////////////////////////////////////////
	// four-phase handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= aluPkg::stateIdle;
			ack <= 1'b0;
			result <= '0;
		end
		else
		begin
			case (state)
				aluPkg::stateIdle:
				begin
					if (req)
						state <= aluPkg::stateCompute;
				end
				aluPkg::stateCompute:
				begin
					result <= nextResult;
					ack <= 1'b1;
					state <= aluPkg::stateHold;
				end
				aluPkg::stateHold:
				begin
					if (!req) // requester released
					begin
						ack <= 1'b0;
						state <= aluPkg::stateIdle;
					end
				end
				default:
					state <= aluPkg::stateIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == aluPkg::stateIdle && req)
		begin
			opReg <= request.op;
			opA <= request.srcA;
			opB <= request.srcB;
		end
	end

	////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextResult.value = intResult.sum;
		nextResult.zero = intResult.zero; // every opcode
		nextResult.invalid = 1'b0;
		case (opReg)
			aluPkg::opAdd: nextResult.value = intResult.sum;
			aluPkg::opSub: nextResult.value = intResult.difference;
			aluPkg::opAnd: nextResult.value = intResult.andValue;
			aluPkg::opOr: nextResult.value = intResult.orValue;
			aluPkg::opSltu:
				nextResult.value = {{(aluPkg::wordWidth-1){1'b0}}, intResult.lessUnsigned};
			aluPkg::opFsgnj: nextResult.value = {opB[signBit], magA};
			aluPkg::opFsgnjn: nextResult.value = {~opB[signBit], magA};
			aluPkg::opFsgnjx: nextResult.value = {opA[signBit] ^ opB[signBit], magA};
			aluPkg::opFmin:
			begin
				nextResult.value = cmpResult.minValue;
				nextResult.invalid = cmpResult.invalidSignaling;
			end
			aluPkg::opFmax:
			begin
				nextResult.value = cmpResult.maxValue;
				nextResult.invalid = cmpResult.invalidSignaling;
			end
			aluPkg::opFeq:
			begin
				nextResult.value = {{(aluPkg::wordWidth-1){1'b0}}, cmpResult.eq};
				nextResult.invalid = cmpResult.invalidSignaling;
			end
			aluPkg::opFlt:
			begin
				nextResult.value = {{(aluPkg::wordWidth-1){1'b0}}, cmpResult.lt};
				nextResult.invalid = cmpResult.invalidQuiet; // quiet NaN also traps
			end
			aluPkg::opFle:
			begin
				nextResult.value = {{(aluPkg::wordWidth-1){1'b0}}, cmpResult.le};
				nextResult.invalid = cmpResult.invalidQuiet;
			end
			aluPkg::opFclass: nextResult.value = {{(aluPkg::wordWidth-10){1'b0}}, classMaskA};
			aluPkg::opFmv: nextResult.value = opA;
			default: nextResult.value = intResult.sum; // unused codes add
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/aluTop.sv
`timescale 1ns/1ps
`default_nettype none

module aluTop
(
	input logic clk,
	input logic reset,
	input logic req,
	input aluPkg::aluRequest_t request,
	output logic ack,
	output aluPkg::aluResult_t result
);

	logic [aluPkg::wordWidth-1:0] opA;
	logic [aluPkg::wordWidth-1:0] opB;
	aluPkg::intResult_t intResult;
	aluPkg::cmpResult_t cmpResult;
	aluPkg::floatCategory_t catA;
	aluPkg::floatCategory_t catB;
	logic [9:0] classMaskA;

	aluControl control
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.request(request),
		.ack(ack),
		.result(result),
		.opA(opA),
		.opB(opB),
		.intResult(intResult),
		.cmpResult(cmpResult),
		.classMaskA(classMaskA)
	);

	intArith arith
	(
		.opA(opA),
		.opB(opB),
		.intResult(intResult)
	);

	floatClassify classA
	(
		.operand(opA),
		.category(catA),
		.classMask(classMaskA)
	);

	// fclass only looks at operand A
	floatClassify classB
	(
		.operand(opB),
		.category(catB),
		.classMask()
	);

	floatCompare compare
	(
		.opA(opA),
		.opB(opB),
		.catA(catA),
		.catB(catB),
		.cmpResult(cmpResult)
	);

endmodule

`default_nettype wire

// File: bench/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model of one request
////////////////////////////////////////////////////////////

function automatic logic isNanValue(input logic [31:0] x);
	return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
endfunction

function automatic logic isSignalingNan(input logic [31:0] x);
	return isNanValue(x) && !x[22]; // quiet bit clear
endfunction

function automatic logic isZeroValue(input logic [31:0] x);
	return x[30:0] == 31'd0;
endfunction

// monotonic key, -0 sorts just below +0
function automatic logic [31:0] orderKey(input logic [31:0] x);
	return x[31] ? ~x : (x | 32'h80000000);
endfunction

function automatic logic floatEqual(input logic [31:0] a, input logic [31:0] b);
	return (isZeroValue(a) && isZeroValue(b)) || (a == b);
endfunction

function automatic logic floatLess(input logic [31:0] a, input logic [31:0] b);
	return !(isZeroValue(a) && isZeroValue(b)) && (orderKey(a) < orderKey(b));
endfunction

function automatic logic [31:0] pickMinMax(input logic [31:0] a, input logic [31:0] b,
	input logic wantMax);
	if (isNanValue(a) && isNanValue(b))
		return aluPkg::canonicalNan;
	else if (isNanValue(a))
		return b;
	else if (isNanValue(b))
		return a;
	else if (wantMax)
		return (orderKey(a) > orderKey(b)) ? a : b;
	else
		return (orderKey(a) < orderKey(b)) ? a : b;
endfunction

function automatic logic [31:0] classBit(input logic [31:0] x);
	int index;
	if (x[30:23] == 8'hff)
		index = (x[22:0] == 23'd0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
	else if (x[30:23] == 8'h00)
		index = (x[22:0] == 23'd0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
	else
		index = x[31] ? 1 : 6;
	return 32'd1 << index;
endfunction

function automatic aluPkg::aluResult_t refAlu(input aluPkg::aluRequest_t rq);
	aluPkg::aluResult_t r;
	logic [31:0] a;
	logic [31:0] b;
	logic anyNan;
	logic anySignaling;
	a = rq.srcA;
	b = rq.srcB;
	anyNan = isNanValue(a) || isNanValue(b);
	anySignaling = isSignalingNan(a) || isSignalingNan(b);
	r.value = a + b;
	r.zero = (a == b);
	r.invalid = 1'b0;
	case (rq.op)
		aluPkg::opSub: r.value = a - b;
		aluPkg::opAnd: r.value = a & b;
		aluPkg::opOr: r.value = a | b;
		aluPkg::opSltu: r.value = (a < b) ? 32'd1 : 32'd0;
		aluPkg::opFsgnj: r.value = {b[31], a[30:0]};
		aluPkg::opFsgnjn: r.value = {~b[31], a[30:0]};
		aluPkg::opFsgnjx: r.value = {a[31] ^ b[31], a[30:0]};
		aluPkg::opFmin: {r.value, r.invalid} = {pickMinMax(a, b, 1'b0), anySignaling};
		aluPkg::opFmax: {r.value, r.invalid} = {pickMinMax(a, b, 1'b1), anySignaling};
		aluPkg::opFeq: {r.value, r.invalid} = {31'd0, !anyNan && floatEqual(a, b), anySignaling};
		aluPkg::opFlt: {r.value, r.invalid} = {31'd0, !anyNan && floatLess(a, b), anyNan};
		aluPkg::opFle:
			{r.value, r.invalid} = {31'd0, !anyNan && (floatLess(a, b) || floatEqual(a, b)),
				anyNan};
		aluPkg::opFclass: r.value = classBit(a);
		aluPkg::opFmv: r.value = a;
		default: r.value = a + b; // add and unused codes
	endcase
	return r;
endfunction

`endif

// File: bench/aluTb.sv
`timescale 1ns/1ps
`default_nettype none

module aluTb;

	localparam int resetCycles = 16;
	localparam int specialCount = 12;
	localparam int intPairs = 80;
	localparam int unusedCodes = 8;
	localparam int signRequests = 40;
	localparam int handshakeRequests = 20;
	localparam int maxHold = 10;
	localparam int requestCount = intPairs + unusedCodes + signRequests
		+ 5 * specialCount * specialCount + 2 * specialCount + handshakeRequests;
	localparam int cycleLimit = resetCycles + 6 * requestCount + maxHold * handshakeRequests + 64;

	logic clk;
	logic reset;
	logic req;
	aluPkg::aluRequest_t request;
	logic ack;
	aluPkg::aluResult_t result;

	logic [31:0] specials [0:specialCount-1];
	logic [4:0] unusedOps [0:unusedCodes-1];
	int checkCount = 0;
	int mismatchCount = 0;
	int cycleCount = 0;
	logic ackSeen = 1'b0;

	`include "aluModel.svh"

	aluTop aluTop_inst
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.request(request),
		.ack(ack),
		.result(result)
	);

	always #20 clk = ~clk;

	task automatic checkEqual(input string label, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			mismatchCount++;
			$display("mismatch at %0t: %s got %h expected %h", $time, label, got, expected);
		end
	endtask

	function automatic logic [31:0] pickOperand();
		int idx;
		idx = int'($urandom % specialCount);
		if ($urandom % 2 == 0)
			return specials[idx];
		else
			return $urandom;
	endfunction

	////////////////////////////////////////////////////////////
	// comparison on each rising ack
	////////////////////////////////////////////////////////////

	task automatic compareResult();
		aluPkg::aluResult_t expected;
		expected = refAlu(request);
		checkEqual($sformatf("op %0d value", request.op), result.value, expected.value);
		checkEqual($sformatf("op %0d zero", request.op), 32'(result.zero), 32'(expected.zero));
		checkEqual($sformatf("op %0d invalid", request.op), 32'(result.invalid),
			32'(expected.invalid));
	endtask

	always @(negedge clk)
	begin
		if (reset)
			ackSeen = 1'b0;
		else
		begin
			if (ack && !ackSeen)
				compareResult();
			ackSeen = ack;
		end
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: ack never arrived within %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	// four-phase request, with latency and hold checks
	task automatic runRequest(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
		input int holdExtra);
		int edges;
		aluPkg::aluResult_t held;
		@(negedge clk);
		request.op = aluPkg::aluOp_t'(op);
		request.srcA = a;
		request.srcB = b;
		req = 1'b1;
		edges = 0;
		while (!ack)
		begin
			@(negedge clk);
			edges++;
		end
		checkEqual("ack latency in edges", edges, 32'd2);
		held = result;
		repeat (holdExtra)
		begin
			@(negedge clk);
			checkEqual("ack during hold", 32'(ack), 32'd1);
			checkEqual("flags during hold", 32'({result.zero, result.invalid}),
				32'({held.zero, held.invalid}));
			checkEqual("value during hold", result.value, held.value);
		end
		req = 1'b0;
		@(negedge clk);
		checkEqual("ack after release", 32'(ack), 32'd0);
	endtask

	initial
	begin
		int i;
		int j;
		int k;
		logic [31:0] a;
		logic [4:0] op;
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		request = '0;
		void'($urandom(37));
		specials = '{32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000, 32'h7fc00000,
			32'hffc00001, 32'h7f800001, 32'hffa00000, 32'h00000001, 32'h807fffff,
			32'h3f800000, 32'hc0000000};
		unusedOps = '{5'd4, 5'd6, 5'd7, 5'd16, 5'd19, 5'd24, 5'd30, 5'd31};
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checkEqual("ack after reset", 32'(ack), 32'd0);
		checkEqual("result value after reset", result.value, 32'd0);
		checkEqual("result flags after reset", 32'({result.zero, result.invalid}), 32'd0);

		for (i = 0; i < intPairs; i++)
		begin
			a = $urandom;
			case (i % 5)
				0: op = aluPkg::opAdd;
				1: op = aluPkg::opSub;
				2: op = aluPkg::opAnd;
				3: op = aluPkg::opOr;
				default: op = aluPkg::opSltu;
			endcase
			runRequest(op, a, (i % 8 == 7) ? a : $urandom, 0); // forced equal pairs
		end
		for (i = 0; i < unusedCodes; i++)
			runRequest(unusedOps[i], $urandom, $urandom, 0);

		for (i = 0; i < signRequests; i++)
		begin
			a = pickOperand();
			case (i % 4)
				0: op = aluPkg::opFsgnj;
				1: op = aluPkg::opFsgnjn;
				2: op = aluPkg::opFsgnjx;
				default: op = aluPkg::opFmv;
			endcase
			runRequest(op, a, (i % 10 == 9) ? a : pickOperand(), 0);
		end

		////////////////////////////////////////////////////////////
		// special table crossed with itself
		////////////////////////////////////////////////////////////

		for (i = 0; i < specialCount; i++)
			for (j = 0; j < specialCount; j++)
				for (k = 0; k < 5; k++)
				begin
					op = 5'(aluPkg::opFmin) + 5'(k); // fmin through fle are consecutive
					runRequest(op, specials[i], specials[j], 0);
				end
		for (i = 0; i < specialCount; i++)
		begin
			runRequest(aluPkg::opFclass, specials[i], pickOperand(), 0);
			runRequest(aluPkg::opFclass, $urandom, pickOperand(), 0);
		end

		for (i = 0; i < handshakeRequests; i++)
		begin
			case (i % 4)
				0: op = aluPkg::opAdd;
				1: op = aluPkg::opFmin;
				2: op = aluPkg::opFsgnjx;
				default: op = aluPkg::opFclass;
			endcase
			runRequest(op, pickOperand(), pickOperand(), int'($urandom % (maxHold + 1)));
		end

		@(negedge clk);
		$display("checks %0d, mismatches %0d", checkCount, mismatchCount);
		if (mismatchCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+bench
verilog/aluPkg.sv
verilog/intArith.sv
verilog/floatClassify.sv
verilog/floatCompare.sv
verilog/aluControl.sv
verilog/aluTop.sv
bench/aluTb.sv

// File: run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module aluTb -o aluSim
./obj_dir/aluSim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
